// ==== include/spu_cfg.svh ====
`ifndef SPU_CFG_SVH
`define SPU_CFG_SVH

// ------------------------------
// sprite file geometry
// ------------------------------
`define SPU_SPRITES   32    // records walked per line
`define SPU_REC_BYTES 8     // xp xs xv yp ys cr al ah

// line buffer
`define SPU_LINE_W    512   // entries per half
`define SPU_LINE_OUT  360   // pixels shifted out per line

// address widths
`define SPU_ADDR_W    21    // dram word address
`define SPU_SF_AW     9     // cpu port and sprite file address
`define SPU_PAL_AW    8     // palette address
`define SPU_X_W       9     // line buffer x, also vline

`endif

// ==== logic/spu_pkg.sv ====
`include "spu_cfg.svh"

package spu_pkg;

	// colour resolution, from cr[1:0]
	typedef enum logic [1:0] {
		CRES_OFF = 2'd0,        // sprite disabled
		CRES_4C  = 2'd1,
		CRES_16C = 2'd2,
		CRES_TC  = 2'd3         // palette bypassed
	} cres_t;

	// byte position inside one record
	typedef enum logic [2:0] {R_XP, R_XS, R_XV, R_YP, R_YS, R_CR, R_AL, R_AH} reg_idx_t;

	typedef enum logic {SEL_SF = 1'b0, SEL_PAL = 1'b1} wr_sel_t;

	// ------------------------------
	// cpu write port
	typedef struct packed {
		logic                  wr;    // one-cycle strobe
		wr_sel_t               sel;
		logic [`SPU_SF_AW-1:0] addr;
		logic [7:0]            data;
	} cpu_wr_t;

	// line buffer entry and output pixel
	typedef struct packed {
		logic       opaque;
		logic [5:0] color;
	} pix_t;

	// one true colour byte
	typedef struct packed {
		logic       rsvd;
		logic       transp;
		logic [5:0] color;
	} tc_pix_t;

	// dram word, pixel 0 in the high bits for every view
	typedef union packed {
		logic [7:0][1:0] c4;
		logic [3:0][3:0] c16;
		tc_pix_t [1:0]   tc;
	} dram_word_u;

	// latched record of the sprite line being fetched
	typedef struct packed {
		cres_t                  mode;
		logic [5:0]             pal;    // palette base
		logic [8:0]             x;      // running write x
		logic [6:0]             width;  // words, counts down while fetching
		logic                   flip;
		logic [`SPU_ADDR_W-1:0] addr;   // current word address
	} spr_line_t;

endpackage

// ==== logic/sprite_regs.sv ====
`timescale 1ns/1ps
`include "spu_cfg.svh"

module sprite_regs
(
	input  logic                   clk,
	input  spu_pkg::cpu_wr_t       cpu_wr,
	input  logic [`SPU_SF_AW-1:0]  sf_ra,
	input  logic [`SPU_PAL_AW-1:0] pal_ra,
	output logic [7:0]             sf_rd,
	output logic [6:0]             pal_rd
);
	import spu_pkg::*;

	localparam int SF_BYTES = `SPU_SPRITES * `SPU_REC_BYTES;   // 256
	localparam int PAL_SIZE = 1 << `SPU_PAL_AW;                 // 256

	logic [7:0] sf_mem [SF_BYTES];    // {sprite, byte} addressed
	logic [6:0] pal_mem [PAL_SIZE];   // bit 6 transparent

	logic lo_half;    // only the lower 256 addresses are mapped
	logic sf_we;
	logic pal_we;

	assign lo_half = !cpu_wr.addr[`SPU_SF_AW-1];
	assign sf_we = cpu_wr.wr && (cpu_wr.sel == SEL_SF) && lo_half;
	assign pal_we = cpu_wr.wr && (cpu_wr.sel == SEL_PAL) && lo_half;

	// ------------------------------
	// cpu writes
	// ------------------------------
	always_ff @(posedge clk)
	begin
		if (sf_we)
			sf_mem[cpu_wr.addr[7:0]] <= cpu_wr.data;
		if (pal_we)
			pal_mem[cpu_wr.addr[7:0]] <= cpu_wr.data[6:0];   // data[7] dropped
	end

	// ------------------------------
	// engine reads
	// ------------------------------

	// attribute file answers in the same cycle
	always_comb
	begin
		if (sf_ra[`SPU_SF_AW-1])
			sf_rd = 8'h00;    // unmapped upper half reads as sprite off
		else
			sf_rd = sf_mem[sf_ra[7:0]];
	end

	// palette lags its address by one clock
	always_ff @(posedge clk)
	begin
		pal_rd <= pal_mem[pal_ra];
	end

endmodule

// ==== logic/sprite_engine.sv ====
`timescale 1ns/1ps
`include "spu_cfg.svh"

module sprite_engine
(
	input  logic                   clk,
	input  logic                   line_start,
	input  logic [`SPU_X_W-1:0]    vline,
	input  logic [7:0]             sf_rd,
	input  logic [6:0]             pal_rd,
	input  logic [15:0]            spu_data,
	input  logic                   spu_strobe,
	output logic [`SPU_SF_AW-1:0]  sf_ra,
	output logic [`SPU_PAL_AW-1:0] pal_ra,
	output logic [`SPU_ADDR_W-1:0] spu_addr,
	output logic                   spu_req,
	output logic [`SPU_X_W-1:0]    wr_x,
	output spu_pkg::pix_t          wr_pix,
	output logic                   wr_en,
	output logic                   busy
);
	import spu_pkg::*;

	typedef enum logic [3:0] {
		S_RES, S_BEG, S_YP, S_YS, S_XS, S_AL, S_AH, S_XV, S_XP,
		S_WAIT, S_WORD, S_EOW, S_HALT
	} state_t;

	localparam logic [4:0] LAST_NUM = 5'(`SPU_SPRITES - 1);

	state_t                 state;
	logic [4:0]             num;        // sprite being walked
	reg_idx_t               idx;        // record byte on the sf read port
	spr_line_t              cur;
	dram_word_u             sdbuf;      // word being unpacked
	logic [7:0]             yp;
	logic [8:0]             lofs;       // line inside the sprite
	logic [2:0]             pcnt;       // pixel within word
	logic [2:0]             p_last;
	logic                   wv;         // write stage valid
	tc_pix_t                tc_q;
	logic [9:0]             y_top, y_end;   // one spare bit, no wrap
	logic [8:0]             ysc, line_rel, lofs_c, x_span;
	logic                   s_act, s_vis, s_last;
	logic [`SPU_ADDR_W-1:0] addr_ofs;

	assign sf_ra = {1'b0, num, idx};
	assign spu_addr = cur.addr;
	assign s_act = cres_t'(sf_rd[1:0]) != CRES_OFF;
	assign s_last = num == LAST_NUM;

	// ------------------------------
	// visibility and line offset, ys on sf_rd
	assign y_top = {1'b0, sf_rd[7], yp};
	assign ysc = {sf_rd[5:0], 3'b000};             // height in lines
	assign y_end = y_top + {1'b0, ysc};
	assign s_vis = ({1'b0, vline} >= y_top) && ({1'b0, vline} < y_end);
	assign line_rel = vline - y_top[8:0];
	assign lofs_c = sf_rd[6] ? (ysc - 9'd1 - line_rel) : line_rel;   // vertical mirror
	assign addr_ofs = `SPU_ADDR_W'(lofs) * `SPU_ADDR_W'(cur.width);

	always_comb
	begin
		case (cur.mode)
			CRES_4C:  p_last = 3'd7;
			CRES_16C: p_last = 3'd3;
			default:  p_last = 3'd1;    // true colour
		endcase
	end

	// pixels per line minus one, flip start offset
	assign x_span = ({2'b00, cur.width} * ({6'b0, p_last} + 9'd1)) - 9'd1;

	// palette lookup address, index picked high first
	always_comb
	begin
		case (cur.mode)
			CRES_4C:  pal_ra = {cur.pal, sdbuf.c4[~pcnt]};
			CRES_16C: pal_ra = {cur.pal[5:2], sdbuf.c16[~pcnt[1:0]]};
			default:  pal_ra = {cur.pal, 2'b00};    // unused in true colour
		endcase
	end

	// ------------------------------
	// walk FSM
	always_ff @(posedge clk or posedge line_start)
	begin
		if (line_start)
		begin
			state <= S_RES;
			num <= '0;
			idx <= R_CR;
			spu_req <= 1'b0;
			busy <= 1'b0;
		end
		else
		begin
			case (state)
				S_RES:
				begin
					busy <= 1'b1;
					num <= '0;
					idx <= R_CR;
					state <= S_BEG;
				end
				S_BEG:    // cr on the port
					if (s_act)
					begin
						cur.mode <= cres_t'(sf_rd[1:0]);
						cur.pal <= sf_rd[7:2];
						idx <= R_YP;
						state <= S_YP;
					end
					else
					begin
						num <= num + 5'd1;    // off, 1 cycle
						idx <= R_CR;
						state <= s_last ? S_HALT : S_BEG;
					end
				S_YP:
				begin
					yp <= sf_rd;
					idx <= R_YS;
					state <= S_YS;
				end
				S_YS:
					if (s_vis)
					begin
						lofs <= lofs_c;
						idx <= R_XS;
						state <= S_XS;
					end
					else
					begin
						num <= num + 5'd1;    // not on this line, 3 cycles
						idx <= R_CR;
						state <= s_last ? S_HALT : S_BEG;
					end
				S_XS:
				begin
					cur.x[8] <= sf_rd[7];
					cur.width <= sf_rd[6:0];
					idx <= R_AL;
					state <= S_AL;
				end
				S_AL:
				begin
					cur.addr[12:0] <= {sf_rd, 5'b00000};
					idx <= R_AH;
					state <= S_AH;
				end
				S_AH:
				begin
					cur.addr <= {sf_rd, cur.addr[12:0]} + addr_ofs;   // first word of line
					if (cur.width == 7'd0)
					begin
						num <= num + 5'd1;    // zero width, nothing to fetch
						idx <= R_CR;
						state <= s_last ? S_HALT : S_BEG;
					end
					else
					begin
						idx <= R_XV;
						state <= S_XV;
					end
				end
				S_XV:
				begin
					cur.flip <= sf_rd[7];
					idx <= R_XP;
					state <= S_XP;
				end
				S_XP:
				begin
					cur.x <= cur.flip ? ({cur.x[8], sf_rd} + x_span) : {cur.x[8], sf_rd};
					spu_req <= 1'b1;
					state <= S_WAIT;
				end
				S_WAIT:
					if (spu_strobe)
					begin
						sdbuf <= spu_data;
						pcnt <= 3'd0;
						state <= S_WORD;
					end
				S_WORD:   // one pixel per clock
				begin
					cur.x <= cur.flip ? (cur.x - 9'd1) : (cur.x + 9'd1);
					pcnt <= pcnt + 3'd1;
					if (pcnt == p_last)
						state <= S_EOW;
				end
				S_EOW:    // last pixel leaves the pipe here
					if (cur.width == 7'd1)
					begin
						spu_req <= 1'b0;
						num <= num + 5'd1;
						idx <= R_CR;
						state <= s_last ? S_HALT : S_BEG;
					end
					else
					begin
						cur.width <= cur.width - 7'd1;
						cur.addr <= cur.addr + 1'b1;  // model sees the new address
						state <= S_WAIT;
					end
				S_HALT:
				begin
					busy <= 1'b0;
					spu_req <= 1'b0;
				end
				default:
					state <= S_HALT;
			endcase
		end
	end

	// ------------------------------
	// write stage, one clock behind the palette address
	always_ff @(posedge clk or posedge line_start)
	begin
		if (line_start)
			wv <= 1'b0;
		else
			wv <= state == S_WORD;
	end

	always_ff @(posedge clk)
	begin
		wr_x <= cur.x;
		tc_q <= sdbuf.tc[~pcnt[0]];
	end

	assign wr_pix = (cur.mode == CRES_TC) ? {!tc_q.transp, tc_q.color}
		: {!pal_rd[6], pal_rd[5:0]};
	assign wr_en = wv && wr_pix.opaque;    // transparent pixels keep what is below

endmodule

// ==== logic/line_buffer.sv ====
`timescale 1ns/1ps
`include "spu_cfg.svh"

module line_buffer
(
	input  logic                clk,
	input  logic                line_start,
	input  logic                pre_vline,
	input  logic [`SPU_X_W-1:0] wr_x,
	input  spu_pkg::pix_t       wr_pix,
	input  logic                wr_en,
	output logic [`SPU_X_W-1:0] vline,
	output spu_pkg::pix_t       pix,
	output logic                pix_strobe
);
	import spu_pkg::*;

	localparam logic [`SPU_X_W-1:0] END_X = `SPU_LINE_OUT;

	pix_t                half0 [`SPU_LINE_W];
	pix_t                half1 [`SPU_LINE_W];
	logic                bank = 1'b0;   // half taking engine writes
	logic [`SPU_X_W-1:0] rd_x;          // readout position
	logic                phase_b;       // clear cycle of the pair
	logic                rd_run, clr_en;
	logic [`SPU_X_W-1:0] wa0, wa1;
	pix_t                wd0, wd1, front;
	logic                we0, we1;

	// ------------------------------
	// per line, swap halves and step vline
	always_ff @(posedge line_start)
	begin
		bank <= ~bank;
		if (pre_vline)
			vline <= '0;    // first line of the frame
		else
			vline <= vline + 1'b1;
	end

	// ------------------------------
	// readout, pixel then clear
	assign rd_run = rd_x != END_X;
	assign clr_en = rd_run && phase_b;

	always_ff @(posedge clk or posedge line_start)
	begin
		if (line_start)
		begin
			rd_x <= '0;
			phase_b <= 1'b0;
			pix.opaque <= 1'b0;
			pix_strobe <= 1'b0;
		end
		else
		begin
			pix_strobe <= 1'b0;
			if (rd_run)
			begin
				if (!phase_b)
				begin
					pix <= front;
					pix_strobe <= 1'b1;
				end
				else
					rd_x <= rd_x + 1'b1;    // entry cleared this cycle
				phase_b <= ~phase_b;
			end
		end
	end

	// back half takes engine writes, front half the clears
	assign wa0 = bank ? rd_x : wr_x;
	assign wd0 = bank ? '0 : wr_pix;
	assign we0 = bank ? clr_en : wr_en;
	assign wa1 = bank ? wr_x : rd_x;
	assign wd1 = bank ? wr_pix : '0;
	assign we1 = bank ? wr_en : clr_en;
	assign front = bank ? half0[rd_x] : half1[rd_x];

	always_ff @(posedge clk)
	begin
		if (we0)
			half0[wa0] <= wd0;
		if (we1)
			half1[wa1] <= wd1;
	end

endmodule

// ==== logic/sprite_unit.sv ====
`timescale 1ns/1ps
`include "spu_cfg.svh"

module sprite_unit
(
	input  logic                   clk,
	input  logic                   line_start,   // async, once per line
	input  logic                   pre_vline,
	input  spu_pkg::cpu_wr_t       cpu_wr,
	input  logic [15:0]            spu_data,
	input  logic                   spu_strobe,
	output logic [`SPU_ADDR_W-1:0] spu_addr,
	output logic                   spu_req,
	output spu_pkg::pix_t          pix,
	output logic                   pix_strobe,
	output logic                   busy
);
	import spu_pkg::*;

	// ------------------------------
	// internal wiring
	logic [`SPU_SF_AW-1:0]  sf_ra;
	logic [7:0]             sf_rd;
	logic [`SPU_PAL_AW-1:0] pal_ra;
	logic [6:0]             pal_rd;
	logic [`SPU_X_W-1:0]    vline;
	logic [`SPU_X_W-1:0]    wr_x;
	pix_t                   wr_pix;
	logic                   wr_en;

	sprite_regs sprite_regs_inst (.clk(clk), .cpu_wr(cpu_wr), .sf_ra(sf_ra),
		.pal_ra(pal_ra), .sf_rd(sf_rd), .pal_rd(pal_rd));

	sprite_engine sprite_engine_inst (.clk(clk), .line_start(line_start), .vline(vline),
		.sf_rd(sf_rd), .pal_rd(pal_rd), .spu_data(spu_data), .spu_strobe(spu_strobe),
		.sf_ra(sf_ra), .pal_ra(pal_ra), .spu_addr(spu_addr), .spu_req(spu_req),
		.wr_x(wr_x), .wr_pix(wr_pix), .wr_en(wr_en), .busy(busy));

	// bank swap and vline live here
	line_buffer line_buffer_inst (.clk(clk), .line_start(line_start), .pre_vline(pre_vline),
		.wr_x(wr_x), .wr_pix(wr_pix), .wr_en(wr_en), .vline(vline), .pix(pix),
		.pix_strobe(pix_strobe));

endmodule

// ==== sim/sprite_unit_assert.sv ====
`timescale 1ns/1ps
`include "spu_cfg.svh"

module sprite_unit_assert
(
	input logic                   clk,
	input logic                   line_start,
	input logic [`SPU_ADDR_W-1:0] spu_addr,
	input logic                   spu_req,
	input logic                   spu_strobe,
	input spu_pkg::pix_t          pix,
	input logic                   pix_strobe,
	input logic                   busy
);
	import spu_pkg::*;

	int fail_cnt = 0;    // read by the testbench

	// ------------------------------
	// dram side
	a_strobe_req: assert property (@(posedge clk) disable iff (line_start)
		spu_strobe |-> spu_req)
	else
	begin
		fail_cnt++;
		$error("error %0t: spu_strobe seen while spu_req low", $time);
	end

	a_req_busy: assert property (@(posedge clk) disable iff (line_start)
		spu_req |-> busy)
	else
	begin
		fail_cnt++;
		$error("error %0t: spu_req high outside the sprite walk", $time);
	end

	// ------------------------------
	// line start and busy
	a_line_start: assert property (@(posedge clk)
		$fell(line_start) |-> !spu_req && !pix_strobe && !busy)
	else
	begin
		fail_cnt++;
		$error("error %0t: outputs not quiet after line_start", $time);
	end

	// walk must be over before the next line
	a_busy_done: assert property (@(posedge clk)
		$rose(line_start) |-> !$past(busy))
	else
	begin
		fail_cnt++;
		$error("error %0t: busy still high at line_start", $time);
	end

	a_busy_low: assert property (@(posedge clk) disable iff (line_start)
		!busy && !$fell(line_start) |=> !busy)
	else
	begin
		fail_cnt++;
		$error("error %0t: busy rose again inside the line", $time);
	end

	// ------------------------------
	// readout, pixel then clear
	a_pix_cadence: assert property (@(posedge clk) disable iff (line_start)
		pix_strobe |=> !pix_strobe)
	else
	begin
		fail_cnt++;
		$error("error %0t: pix_strobe high two cycles in a row", $time);
	end

	a_transp_zero: assert property (@(posedge clk) disable iff (line_start)
		pix_strobe && !pix.opaque |-> pix.color == 6'd0)
	else
	begin
		fail_cnt++;
		$error("error %0t: transparent pixel with colour %h", $time, pix.color);
	end

endmodule

// ==== sim/sprite_unit_tb.sv ====
`timescale 1ns/1ps
`include "spu_cfg.svh"

module sprite_unit_tb;
	import spu_pkg::*;

	localparam int LINE_CYC  = 1024;
	localparam int LAST_LINE = 10;    // lines 0..10, then one closing line_start

	logic                   clk;
	logic                   line_start;
	logic                   pre_vline;
	cpu_wr_t                cpu_wr;
	logic [15:0]            spu_data;
	logic                   spu_strobe;
	logic [`SPU_ADDR_W-1:0] spu_addr;
	logic                   spu_req;
	pix_t                   pix;
	logic                   pix_strobe;
	logic                   busy;

	logic [7:0]             rec [`SPU_SPRITES][`SPU_REC_BYTES];   // shadow of the sprite file
	logic [6:0]             pal_sh [256];
	pix_t                   exp_rend [`SPU_LINE_OUT];   // line being rendered
	pix_t                   exp_show [`SPU_LINE_OUT];   // line being shown
	logic [`SPU_ADDR_W-1:0] got_addr [$];
	logic [`SPU_ADDR_W-1:0] exp_addr [$];
	int                     cyc = 0;
	int                     t_line = -LINE_CYC;
	int                     line_no = 0;    // tb copy of vline
	int                     rd_k = 0;
	int                     err_cnt = 0;
	int                     afail;
	int                     v;

	sprite_unit sprite_unit_inst (.*);

	bind sprite_unit sprite_unit_assert sprite_unit_assert_inst (.*);

	initial
	begin
		clk = 1'b1;    // first edge is a falling one
		forever #2 clk = ~clk;
	end

	always @(posedge clk)
		cyc <= cyc + 1;

	// dram word rule
	function automatic logic [15:0] dram_word(input logic [`SPU_ADDR_W-1:0] a);
		return {a[7:0] ^ 8'ha5, a[15:8]};
	endfunction

	function automatic logic [6:0] pal_val(input logic [7:0] a);
		return 7'((a * 8'd29) ^ (a >> 5));    // bit 6 set on some entries
	endfunction

	// ------------------------------
	// dram model, one word in flight
	initial
	begin : dram_model
		logic [`SPU_ADDR_W-1:0] served;
		logic                   have_word;
		int                     dly;
		spu_strobe = 1'b0;
		spu_data = '0;
		have_word = 1'b0;
		served = '0;
		void'($urandom(32'h674d));
		forever
		begin
			@(negedge clk);
			if (!spu_req)
				have_word = 1'b0;
			else if (!have_word || spu_addr != served)
			begin
				if (!have_word)
					got_addr.push_back(spu_addr);    // first word of a sprite line
				have_word = 1'b1;
				served = spu_addr;
				dly = $urandom % 6;
				repeat (dly) @(negedge clk);
				if (spu_req)
				begin
					spu_data = dram_word(spu_addr);
					spu_strobe = 1'b1;
					@(negedge clk);
					spu_strobe = 1'b0;
				end
			end
		end
	end

	task automatic cpu_write(input wr_sel_t sel, input logic [8:0] addr, input logic [7:0] data);
		cpu_wr.wr = 1'b1;
		cpu_wr.sel = sel;
		cpu_wr.addr = addr;
		cpu_wr.data = data;
		@(negedge clk);
		cpu_wr.wr = 1'b0;
	endtask

	task automatic fill_tables();
		int a;
		for (a = 0; a < 256; a++)
		begin
			rec[a / 8][a % 8] = 8'h00;    // every sprite off
			cpu_write(SEL_SF, 9'(a), 8'h00);
			pal_sh[a] = pal_val(8'(a));
			cpu_write(SEL_PAL, 9'(a), {1'b0, pal_val(8'(a))});
		end
	endtask

	// bytes in record order xp xs xv yp ys cr al ah
	task automatic set_record(input int s, input logic [7:0] b0, b1, b2, b3, b4, b5, b6, b7);
		logic [7:0] b [8];
		int i;
		b = '{b0, b1, b2, b3, b4, b5, b6, b7};
		for (i = 0; i < 8; i++)
		begin
			rec[s][i] = b[i];
			cpu_write(SEL_SF, 9'(s * 8 + i), b[i]);
		end
	endtask

	// records for the line about to be rendered
	task automatic set_scene(input int vl);
		case (vl)
			2: set_record(3, 8'd40, 8'h03, 8'h00, 8'd0, 8'h01, 8'h52, 8'h12, 8'h03);   // 16c
			3: set_record(5, 8'd44, 8'h82, 8'h80, 8'd1, 8'h42, 8'had, 8'h40, 8'h00);   // 4c flip
			4: set_record(7, 8'd100, 8'h04, 8'h00, 8'd4, 8'h01, 8'h03, 8'h9c, 8'h07);  // tc
			5:
			begin
				// overlap on top of sprite 3
				set_record(8, 8'd44, 8'h02, 8'h00, 8'd5, 8'h01, 8'hc2, 8'h21, 8'h01);
				set_record(9, 8'd48, 8'h02, 8'h00, 8'd5, 8'h01, 8'h22, 8'h77, 8'h02);
			end
			9: set_record(7, 8'd100, 8'h04, 8'h00, 8'd4, 8'h01, 8'h00, 8'h9c, 8'h07);  // off
			default: ;
		endcase
	endtask

	// ------------------------------
	// expected line from the record rules
	task automatic build_line(input logic [8:0] vl);
		logic [9:0]             y;
		logic [8:0]             h, lo, x0, x;
		logic [`SPU_ADDR_W-1:0] addr;
		logic [15:0]            wd;
		logic [6:0]             pe;
		logic [1:0]             mode;
		logic [5:0]             pb;
		int                     s, w, p, n, k, wid, npx;
		for (k = 0; k < `SPU_LINE_OUT; k++)
			exp_rend[k] = '0;
		for (s = 0; s < `SPU_SPRITES; s++)
		begin
			mode = rec[s][5][1:0];
			pb = rec[s][5][7:2];
			y = {1'b0, rec[s][4][7], rec[s][3]};
			h = {rec[s][4][5:0], 3'b000};
			wid = int'(rec[s][1][6:0]);
			if (mode == 2'd0 || {1'b0, vl} < y || {1'b0, vl} >= y + h || wid == 0)
				continue;
			lo = vl - y[8:0];
			if (rec[s][4][6])
				lo = h - 9'd1 - lo;    // vertical mirror
			addr = {rec[s][7], rec[s][6], 5'b00000} + `SPU_ADDR_W'(lo) * `SPU_ADDR_W'(wid);
			exp_addr.push_back(addr);
			npx = (mode == 2'd1) ? 8 : (mode == 2'd2) ? 4 : 2;
			x0 = {rec[s][1][7], rec[s][0]};
			for (w = 0; w < wid; w++)
			begin
				wd = dram_word(addr + `SPU_ADDR_W'(w));
				for (p = 0; p < npx; p++)
				begin
					n = w * npx + p;
					x = rec[s][2][7] ? x0 + 9'(wid * npx - 1 - n) : x0 + 9'(n);
					case (mode)
						2'd1: pe = pal_sh[{pb, wd[15 - 2 * p -: 2]}];
						2'd2: pe = pal_sh[{pb[5:2], wd[15 - 4 * p -: 4]}];
						default: pe = wd[14 - 8 * p -: 7];    // tc byte, same layout
					endcase
					if (!pe[6] && x < 9'(`SPU_LINE_OUT))
						exp_rend[x] = {1'b1, pe[5:0]};    // later sprite wins
				end
			end
		end
	endtask

	// ------------------------------
	// line sequencing
	task automatic start_line(input logic pv, input int hold);
		while (cyc - t_line < LINE_CYC)
			@(negedge clk);
		if (line_no >= 2)
			assert (rd_k == `SPU_LINE_OUT)
			else
			begin
				err_cnt++;
				$display("error %0t: line %0d shifted out %0d pixels, expected %0d",
					$time, line_no, rd_k, `SPU_LINE_OUT);
			end
		pre_vline = pv;    // settles one cycle before the edge
		@(negedge clk);
		line_start = 1'b1;
		repeat (hold) @(negedge clk);
		line_start = 1'b0;
		pre_vline = 1'b0;
		t_line = cyc;
		line_no = pv ? 0 : line_no + 1;
		rd_k = 0;
		exp_show = exp_rend;
		got_addr.delete();
		exp_addr.delete();
		build_line(9'(line_no));
		@(negedge clk);
	endtask

	task automatic finish_line();
		int i;
		while (busy)
			@(negedge clk);
		if (line_no >= 1)
		begin
			assert (got_addr.size() == exp_addr.size())
			else
			begin
				err_cnt++;
				$display("error %0t: line %0d made %0d dram requests, expected %0d",
					$time, line_no, got_addr.size(), exp_addr.size());
			end
			for (i = 0; i < got_addr.size() && i < exp_addr.size(); i++)
				assert (got_addr[i] == exp_addr[i])
				else
				begin
					err_cnt++;
					$display("error %0t: first spu_addr %h, expected %h",
						$time, got_addr[i], exp_addr[i]);
				end
		end
	endtask

	// pixel compare, sampled mid-cycle
	always @(negedge clk)
	begin
		if (pix_strobe && line_no >= 2)
			assert (rd_k < `SPU_LINE_OUT && pix == exp_show[rd_k])
			else
			begin
				err_cnt++;
				$display("error %0t: line %0d pixel %0d is %h, expected %h",
					$time, line_no, rd_k, pix, exp_show[rd_k]);
			end
		if (pix_strobe)
			rd_k++;
	end

	// ------------------------------
	// main sequence
	initial
	begin
		line_start = 1'b0;
		pre_vline = 1'b1;
		cpu_wr = '0;
		start_line(1'b1, 8);    // frame start, vline 0
		fill_tables();
		finish_line();
		for (v = 1; v <= LAST_LINE; v++)
		begin
			set_scene(v);
			start_line(1'b0, 1);
			finish_line();
		end
		start_line(1'b0, 1);    // closes the last shown line
		afail = sprite_unit_inst.sprite_unit_assert_inst.fail_cnt;
		$display("errors: %0d in pixel and address checks, %0d in assertions", err_cnt, afail);
		if (err_cnt == 0 && afail == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

	// watchdog, two spare lines
	initial
	begin
		repeat ((LAST_LINE + 1 + 2) * LINE_CYC) @(posedge clk);
		$display("timeout: the run did not finish in the expected number of cycles");
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

// ==== flist.f ====
+incdir+include
logic/spu_pkg.sv
logic/sprite_regs.sv
logic/sprite_engine.sv
logic/line_buffer.sv
logic/sprite_unit.sv
sim/sprite_unit_assert.sv
sim/sprite_unit_tb.sv

// ==== Makefile ====
TOOL  = verilator
FLAGS = --binary --timing --assert
TOP   = sprite_unit_tb
FLIST = flist.f

.PHONY: sim clean

# the run log is searched for the pass line, the exit code of the run is not used
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) +verilator+error+limit+1000 > sim.log 2>&1 || true
	cat sim.log
	grep -q "^STATUS: PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log
